/* src/muldiv_pkg.sv */
package muldiv_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    // operand and result width
    localparam int unsigned XLEN = 32;
    // up to eight outstanding ids
    localparam int unsigned TRANS_ID_BITS = 3;
    // width of the operation code
    localparam int unsigned OP_BITS = 4;
    // iteration counter of the serial divider
    localparam int unsigned DIV_CNT_BITS = $clog2(XLEN);
    // most negative signed value, also |min| as unsigned magnitude
    localparam logic [XLEN-1:0] XLEN_MIN = {1'b1, {(XLEN-1){1'b0}}};

    // ------------------------------------------------------------------------
    // operations
    // ------------------------------------------------------------------------
    typedef enum logic [OP_BITS-1:0] {
        MUL    = 4'd0,
        MULH   = 4'd1,
        MULHSU = 4'd2,
        MULHU  = 4'd3,
        DIV    = 4'd4,
        DIVU   = 4'd5,
        REM    = 4'd6,
        REMU   = 4'd7
    } fu_op_e;

    // operation sets, one bit per encoding, indexed by the op code
    // upper product word wanted
    localparam logic [2**OP_BITS-1:0] MUL_HIGH_OPS = 16'h000E;
    // first operand is signed: MULH, MULHSU, DIV, REM
    localparam logic [2**OP_BITS-1:0] SIGNED_A_OPS = 16'h0056;
    // second operand is signed: MULH, DIV, REM
    localparam logic [2**OP_BITS-1:0] SIGNED_B_OPS = 16'h0052;
    // remainder instead of quotient
    localparam logic [2**OP_BITS-1:0] REM_OPS      = 16'h00C0;

endpackage

/* src/muldiv_req_if.sv */
`timescale 1ns/1ps

interface muldiv_req_if;
    import muldiv_pkg::*;

    // request strobe, only raised towards the unit of the matching class
    logic                     valid;
    fu_op_e                   op;
    // raw operands for the multiplier, magnitudes for the divider
    logic [XLEN-1:0]          operand_a;
    logic [XLEN-1:0]          operand_b;
    logic [TRANS_ID_BITS-1:0] trans_id;
    // operand is signed and negative
    logic                     neg_a;
    logic                     neg_b;
    // divider only: negate the selected result, select the remainder
    logic                     neg_res;
    logic                     rem;

    // decode side
    modport master (
        output valid, op, operand_a, operand_b, trans_id,
        output neg_a, neg_b, neg_res, rem
    );

    // execution unit side
    modport slave (
        input valid, op, operand_a, operand_b, trans_id,
        input neg_a, neg_b, neg_res, rem
    );

endinterface

/* src/muldiv_res_if.sv */
`timescale 1ns/1ps

interface muldiv_res_if;
    import muldiv_pkg::*;

    // transfer happens when valid and ready are both high
    logic                     valid;
    logic                     ready;
    logic [XLEN-1:0]          result;
    logic [TRANS_ID_BITS-1:0] trans_id;

    // execution unit side, fields stay stable while held
    modport master (
        output valid, result, trans_id,
        input  ready
    );

    // write-back merge side
    modport slave (
        input  valid, result, trans_id,
        output ready
    );

endinterface

/* src/muldiv_decode.sv */
`timescale 1ns/1ps

module muldiv_decode (
    input  logic                                 valid_i,
    input  logic                                 flush_i,
    input  logic                                 div_ready_i,
    input  muldiv_pkg::fu_op_e                   op_i,
    input  logic [muldiv_pkg::XLEN-1:0]          operand_a_i,
    input  logic [muldiv_pkg::XLEN-1:0]          operand_b_i,
    input  logic [muldiv_pkg::TRANS_ID_BITS-1:0] trans_id_i,
    muldiv_req_if.master                         mul_req,
    muldiv_req_if.master                         div_req
);
    import muldiv_pkg::*;

    logic            issue;
    logic            is_mul;
    logic            is_div;
    logic            sign_a;
    logic            sign_b;
    logic            div_zero;
    logic            rem_op;
    logic [XLEN-1:0] mag_a;
    logic [XLEN-1:0] mag_b;

    // ------------------------------------------------------------------------
    // classification
    // ------------------------------------------------------------------------
    // no issue during flush, and only while the divider is idle
    assign issue  = valid_i && !flush_i && div_ready_i;
    assign is_mul = op_i inside {MUL, MULH, MULHSU, MULHU};
    assign is_div = op_i inside {DIV, DIVU, REM, REMU};

    // operand is negative only when the operation treats it as signed
    assign sign_a   = SIGNED_A_OPS[op_i] && operand_a_i[XLEN-1];
    assign sign_b   = SIGNED_B_OPS[op_i] && operand_b_i[XLEN-1];
    assign div_zero = (operand_b_i == '0);
    assign rem_op   = REM_OPS[op_i];

    // absolute values, the divider works on unsigned magnitudes only
    // note: |min| stays 0x8000_0000, which is right as an unsigned value
    assign mag_a = sign_a ? -operand_a_i : operand_a_i;
    assign mag_b = sign_b ? -operand_b_i : operand_b_i;

    // ------------------------------------------------------------------------
    // multiplier request
    // ------------------------------------------------------------------------
    assign mul_req.valid     = issue && is_mul;
    assign mul_req.op        = op_i;
    assign mul_req.operand_a = operand_a_i;
    assign mul_req.operand_b = operand_b_i;
    assign mul_req.trans_id  = trans_id_i;
    // sign flags become the extension bit of the 33-bit operands
    assign mul_req.neg_a     = sign_a;
    assign mul_req.neg_b     = sign_b;
    assign mul_req.neg_res   = 1'b0;
    assign mul_req.rem       = 1'b0;

    // ------------------------------------------------------------------------
    // divider request
    // ------------------------------------------------------------------------
    assign div_req.valid     = issue && is_div;
    assign div_req.op        = op_i;
    assign div_req.operand_a = mag_a;
    assign div_req.operand_b = mag_b;
    assign div_req.trans_id  = trans_id_i;
    // signs are kept so the divider can spot min / -1
    assign div_req.neg_a     = sign_a;
    assign div_req.neg_b     = sign_b;
    // remainder takes the dividend sign, quotient the xor of both signs
    // division by zero must leave the all-ones quotient untouched
    assign div_req.neg_res   = rem_op ? sign_a : ((sign_a ^ sign_b) && !div_zero);
    assign div_req.rem       = rem_op;

endmodule

/* src/pipe_multiplier.sv */
`timescale 1ns/1ps

module pipe_multiplier (
    input  logic          clk_i,
    input  logic          rst_ni,
    muldiv_req_if.slave   req,
    muldiv_res_if.master  res
);
    import muldiv_pkg::*;

    // stage 1, sign-extended operands
    logic                     valid1_q;
    logic [XLEN:0]            a_q;
    logic [XLEN:0]            b_q;
    logic                     high_q;
    logic [TRANS_ID_BITS-1:0] id1_q;

    // stage 2, selected product word
    logic                     valid2_q;
    logic [XLEN-1:0]          result_q;
    logic [TRANS_ID_BITS-1:0] id2_q;

    // full 66-bit signed product of the stage 1 operands
    logic signed [2*XLEN+1:0] product;

    assign product = $signed(a_q) * $signed(b_q);

    // ------------------------------------------------------------------------
    // valid pipeline
    // ------------------------------------------------------------------------
    // result valid is the request valid shifted by two stages
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid1_q <= 1'b0;
            valid2_q <= 1'b0;
        end else begin
            valid1_q <= req.valid;
            valid2_q <= valid1_q;
        end
    end

    // ------------------------------------------------------------------------
    // data pipeline
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        // stage 1 only loads on a request
        if (req.valid) begin
            // extension bit set only for a signed negative operand
            a_q    <= {req.neg_a, req.operand_a};
            b_q    <= {req.neg_b, req.operand_b};
            high_q <= MUL_HIGH_OPS[req.op];
            id1_q  <= req.trans_id;
        end
        // stage 2 picks the word, MUL takes the low half
        if (valid1_q) begin
            if (high_q) begin
                result_q <= product[2*XLEN-1:XLEN];
            end else begin
                result_q <= product[XLEN-1:0];
            end
            id2_q <= id1_q;
        end
    end

    // ------------------------------------------------------------------------
    // result port
    // ------------------------------------------------------------------------
    // the merge always takes this result, so ready is never looked at
    assign res.valid    = valid2_q;
    assign res.result   = result_q;
    assign res.trans_id = id2_q;

endmodule

/* src/serial_divider.sv */
`timescale 1ns/1ps

module serial_divider (
    input  logic          clk_i,
    input  logic          rst_ni,
    input  logic          flush_i,
    muldiv_req_if.slave   req,
    muldiv_res_if.master  res,
    output logic          ready_o
);
    import muldiv_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        DIVIDE,
        FIXUP,
        DONE
    } state_e;

    localparam logic [DIV_CNT_BITS-1:0] CNT_LAST = DIV_CNT_BITS'(XLEN - 1);

    state_e                   state_q;
    logic [DIV_CNT_BITS-1:0]  cnt_q;

    // datapath registers
    logic [XLEN-1:0]          quo_q;
    logic [XLEN-1:0]          rem_q;
    logic [XLEN-1:0]          div_q;
    logic [XLEN-1:0]          result_q;
    logic [TRANS_ID_BITS-1:0] id_q;
    logic                     neg_res_q;
    logic                     rem_sel_q;
    logic                     special_q;

    logic                     accept;
    logic                     div_zero;
    logic                     overflow;
    logic [XLEN:0]            partial;
    logic [XLEN:0]            diff;
    logic [XLEN-1:0]          fix_val;
    logic [XLEN-1:0]          fix_res;

    // ------------------------------------------------------------------------
    // input side
    // ------------------------------------------------------------------------
    assign accept   = req.valid && (state_q == IDLE);
    assign div_zero = (req.operand_b == '0);
    // min / -1, seen as magnitudes 0x8000_0000 and 1 with both signs set
    assign overflow = req.neg_a && req.neg_b &&
                      (req.operand_a == XLEN_MIN) && (req.operand_b == XLEN'(1));

    // ------------------------------------------------------------------------
    // restoring step and sign fix-up
    // ------------------------------------------------------------------------
    // shift next dividend bit into the partial remainder, then trial subtract
    assign partial = {rem_q, quo_q[XLEN-1]};
    assign diff    = partial - {1'b0, div_q};

    // pick remainder or quotient, negate if the signs asked for it
    assign fix_val = rem_sel_q ? rem_q : quo_q;
    assign fix_res = neg_res_q ? -fix_val : fix_val;

    // ------------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else if (flush_i) begin
            // drop whatever is in flight
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        state_q <= DIVIDE;
                        cnt_q   <= '0;
                    end
                end
                DIVIDE: begin
                    // special cases skip the iterations
                    if (special_q) begin
                        state_q <= DONE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                        if (cnt_q == CNT_LAST) begin
                            state_q <= FIXUP;
                        end
                    end
                end
                FIXUP: begin
                    state_q <= DONE;
                end
                DONE: begin
                    // hold until the merge takes it
                    if (res.ready) begin
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (accept) begin
            // div by zero: quotient all ones, remainder the dividend
            // overflow: quotient |min|, remainder zero, both fall out of this load
            quo_q     <= div_zero ? '1 : req.operand_a;
            rem_q     <= div_zero ? req.operand_a : '0;
            div_q     <= req.operand_b;
            id_q      <= req.trans_id;
            neg_res_q <= req.neg_res;
            rem_sel_q <= req.rem;
            special_q <= div_zero || overflow;
        end else if ((state_q == DIVIDE) && !special_q) begin
            // one quotient bit per cycle, msb first
            if (!diff[XLEN]) begin
                rem_q <= diff[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q <= partial[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end
        // final result, shared by the normal path and the special cases
        if ((state_q == FIXUP) || ((state_q == DIVIDE) && special_q)) begin
            result_q <= fix_res;
        end
    end

    // ------------------------------------------------------------------------
    // outputs
    // ------------------------------------------------------------------------
    assign ready_o      = (state_q == IDLE);
    assign res.valid    = (state_q == DONE);
    assign res.result   = result_q;
    assign res.trans_id = id_q;

endmodule

/* src/muldiv_unit.sv */
`timescale 1ns/1ps

module muldiv_unit (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  logic                                 flush_i,
    input  logic                                 valid_i,
    input  muldiv_pkg::fu_op_e                   op_i,
    input  logic [muldiv_pkg::XLEN-1:0]          operand_a_i,
    input  logic [muldiv_pkg::XLEN-1:0]          operand_b_i,
    input  logic [muldiv_pkg::TRANS_ID_BITS-1:0] trans_id_i,
    output logic                                 ready_o,
    output logic                                 valid_o,
    output logic [muldiv_pkg::XLEN-1:0]          result_o,
    output logic [muldiv_pkg::TRANS_ID_BITS-1:0] trans_id_o
);

    // divider idle flag, also gates the issue in decode
    logic div_ready;

    muldiv_req_if mul_req ();
    muldiv_req_if div_req ();
    muldiv_res_if mul_res ();
    muldiv_res_if div_res ();

    // ------------------------------------------------------------------------
    // decode
    // ------------------------------------------------------------------------
    muldiv_decode i_decode (
        .valid_i     (valid_i),
        .flush_i     (flush_i),
        .div_ready_i (div_ready),
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .trans_id_i  (trans_id_i),
        .mul_req     (mul_req),
        .div_req     (div_req)
    );

    // ------------------------------------------------------------------------
    // execution units
    // ------------------------------------------------------------------------
    pipe_multiplier i_multiplier (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .req    (mul_req),
        .res    (mul_res)
    );

    serial_divider i_divider (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_i),
        .req     (div_req),
        .res     (div_res),
        .ready_o (div_ready)
    );

    // ------------------------------------------------------------------------
    // write-back merge
    // ------------------------------------------------------------------------
    // multiplier wins, it has no way to stall
    // the divider holds its result until the port is free
    assign mul_res.ready = 1'b1;
    assign div_res.ready = !mul_res.valid;

    assign valid_o    = mul_res.valid || div_res.valid;
    assign result_o   = mul_res.valid ? mul_res.result   : div_res.result;
    assign trans_id_o = mul_res.valid ? mul_res.trans_id : div_res.trans_id;

    // a multiply is also only issued while the divider is idle
    assign ready_o = div_ready;

endmodule

/* test/muldiv_checker.sv */
`timescale 1ns/1ps

module muldiv_checker (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  logic                                 flush_i,
    input  logic                                 valid_i,
    input  muldiv_pkg::fu_op_e                   op_i,
    input  logic [muldiv_pkg::XLEN-1:0]          operand_a_i,
    input  logic [muldiv_pkg::XLEN-1:0]          operand_b_i,
    input  logic [muldiv_pkg::TRANS_ID_BITS-1:0] trans_id_i,
    input  logic                                 ready_i,
    input  logic                                 res_valid_i,
    input  logic [muldiv_pkg::XLEN-1:0]          result_i,
    input  logic [muldiv_pkg::TRANS_ID_BITS-1:0] res_id_i,
    output int unsigned                          error_count_o,
    output int unsigned                          pending_count_o
);
    import muldiv_pkg::*;

    localparam int NUM_IDS = 2 ** TRANS_ID_BITS;

    // expected-result table, one slot per transaction id
    logic [XLEN-1:0]          exp_result [NUM_IDS];
    logic                     pending    [NUM_IDS];
    logic                     is_div     [NUM_IDS];
    int unsigned              issue_cyc  [NUM_IDS];
    logic [TRANS_ID_BITS-1:0] slot;
    int unsigned              cycle;
    int unsigned              errors = 0;
    int unsigned              outstanding;
    // a divide is in flight, the unit must not be ready
    logic                     div_busy;

    assign error_count_o   = errors;
    assign pending_count_o = outstanding;

    // ------------------------------------------------------------------------
    // RISC-V M reference
    // ------------------------------------------------------------------------
    function automatic logic [XLEN-1:0] muldiv_ref(fu_op_e op, logic [XLEN-1:0] a,
                                                   logic [XLEN-1:0] b);
        logic [2*XLEN-1:0]      p_ss;
        logic [2*XLEN-1:0]      p_su;
        logic [2*XLEN-1:0]      p_uu;
        logic signed [XLEN-1:0] da;
        logic signed [XLEN-1:0] db;
        logic signed [XLEN-1:0] sq;
        logic signed [XLEN-1:0] sr;
        logic                   ovf;
        // products mod 2^64 of the extended operands give the right high words
        p_ss = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{b[XLEN-1]}}, b};
        p_su = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{1'b0}}, b};
        p_uu = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        da   = a;
        db   = b;
        ovf  = (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1);
        sq   = '0;
        sr   = '0;
        if ((b != '0) && !ovf) begin
            sq = da / db;
            sr = da % db;
        end
        case (op)
            MUL:     return p_uu[XLEN-1:0];
            MULH:    return p_ss[2*XLEN-1:XLEN];
            MULHSU:  return p_su[2*XLEN-1:XLEN];
            MULHU:   return p_uu[2*XLEN-1:XLEN];
            // by zero: all ones, overflow: the dividend itself
            DIV:     return (b == '0) ? '1 : (ovf ? a : sq);
            DIVU:    return (b == '0) ? '1 : a / b;
            // by zero: the dividend, overflow: zero
            REM:     return (b == '0) ? a : (ovf ? '0 : sr);
            REMU:    return (b == '0) ? a : a % b;
            default: return '0;
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // sampling at the falling edge, all ports are settled there
    // ------------------------------------------------------------------------
    always @(negedge clk_i) begin
        if (!rst_ni) begin
            for (int i = 0; i < NUM_IDS; i++) begin
                slot          = TRANS_ID_BITS'(i);
                pending[slot] = 1'b0;
            end
            outstanding = 0;
            div_busy    = 1'b0;
            cycle       = 0;
        end else begin
            cycle++;
            // ready_o mirrors the divider, multiplies never pull it low
            if (ready_i !== !div_busy) begin
                $display("[ERROR] ready_o expected %h actual %h", !div_busy, ready_i);
                errors++;
            end
            // write-back
            if (res_valid_i === 1'b1) begin
                if (pending[res_id_i] !== 1'b1) begin
                    $display("result for id %0d arrived, but that id is not outstanding",
                             res_id_i);
                    errors++;
                end else begin
                    if (result_i !== exp_result[res_id_i]) begin
                        $display("[ERROR] result_o id %0d expected %h actual %h",
                                 res_id_i, exp_result[res_id_i], result_i);
                        errors++;
                    end
                    // fixed multiply latency
                    if (!is_div[res_id_i] && (cycle - issue_cyc[res_id_i] != 2)) begin
                        $display("multiply id %0d took %0d cycles instead of 2",
                                 res_id_i, cycle - issue_cyc[res_id_i]);
                        errors++;
                    end
                    if (is_div[res_id_i]) begin
                        div_busy = 1'b0;
                    end
                    pending[res_id_i] = 1'b0;
                    outstanding--;
                end
            end
            // a flush drops the divide in flight
            if ((flush_i === 1'b1) && div_busy) begin
                for (int i = 0; i < NUM_IDS; i++) begin
                    slot = TRANS_ID_BITS'(i);
                    if (pending[slot] && is_div[slot]) begin
                        pending[slot] = 1'b0;
                        outstanding--;
                    end
                end
                div_busy = 1'b0;
            end
            // accepted issue
            if ((valid_i === 1'b1) && (ready_i === 1'b1) && (flush_i === 1'b0)) begin
                if (pending[trans_id_i] === 1'b1) begin
                    $display("id %0d issued again while still outstanding", trans_id_i);
                    errors++;
                end
                exp_result[trans_id_i] = muldiv_ref(op_i, operand_a_i, operand_b_i);
                is_div[trans_id_i]     = op_i inside {DIV, DIVU, REM, REMU};
                issue_cyc[trans_id_i]  = cycle;
                pending[trans_id_i]    = 1'b1;
                outstanding++;
                if (op_i inside {DIV, DIVU, REM, REMU}) begin
                    div_busy = 1'b1;
                end
            end
        end
    end

endmodule

/* test/tb_muldiv_unit.sv */
`timescale 1ns/1ps

module tb_muldiv_unit;
    import muldiv_pkg::*;

    localparam int CLK_HALF_NS  = 50;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_RANDOM   = 300;
    // 8 by zero, 4 min by -1, 72 small operands, 4 MULHSU
    localparam int NUM_CORNER   = 88;
    localparam int NUM_MEET     = 8;
    localparam int NUM_FLUSH    = 9;
    localparam int NUM_OPS      = 2 * NUM_RANDOM + NUM_CORNER + NUM_MEET + NUM_FLUSH;
    // 40 cycles per operation is well above the slowest divide
    localparam longint TIMEOUT_NS =
        longint'(NUM_OPS * 40 + 200 + RESET_CYCLES) * 2 * CLK_HALF_NS;
    localparam logic [31:0] SEED = 32'h1ff85485;

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     flush;
    logic                     issue_valid;
    fu_op_e                   op;
    logic [XLEN-1:0]          operand_a;
    logic [XLEN-1:0]          operand_b;
    logic [TRANS_ID_BITS-1:0] trans_id;
    logic                     ready;
    logic                     res_valid;
    logic [XLEN-1:0]          result;
    logic [TRANS_ID_BITS-1:0] res_id;
    int unsigned              chk_errors;
    int unsigned              pending_count;
    int unsigned              tb_errors;
    // ids rotate, at most three are ever in flight
    logic [TRANS_ID_BITS-1:0] next_id;
    logic [XLEN-1:0]          small_vals [3];

    always #CLK_HALF_NS clk = ~clk;

    muldiv_unit i_dut (
        .clk_i       (clk),
        .rst_ni      (rst_n),
        .flush_i     (flush),
        .valid_i     (issue_valid),
        .op_i        (op),
        .operand_a_i (operand_a),
        .operand_b_i (operand_b),
        .trans_id_i  (trans_id),
        .ready_o     (ready),
        .valid_o     (res_valid),
        .result_o    (result),
        .trans_id_o  (res_id)
    );

    muldiv_checker i_checker (
        .clk_i           (clk),
        .rst_ni          (rst_n),
        .flush_i         (flush),
        .valid_i         (issue_valid),
        .op_i            (op),
        .operand_a_i     (operand_a),
        .operand_b_i     (operand_b),
        .trans_id_i      (trans_id),
        .ready_i         (ready),
        .res_valid_i     (res_valid),
        .result_i        (result),
        .res_id_i        (res_id),
        .error_count_o   (chk_errors),
        .pending_count_o (pending_count)
    );

    // ------------------------------------------------------------------------
    // stimulus helpers, called 1 ns after a rising edge
    // ------------------------------------------------------------------------
    task automatic issue_op(input fu_op_e op_in, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b);
        // only offered while the divider is idle
        while (ready !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        issue_valid = 1'b1;
        op          = op_in;
        operand_a   = a;
        operand_b   = b;
        trans_id    = next_id;
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
        next_id     = next_id + 1'b1;
    endtask

    task automatic flush_divide(input fu_op_e div_op, input int wait_cycles);
        // positive nonzero divisor, so the divide takes the long path
        issue_op(div_op, $urandom, ($urandom | 32'h1) & 32'h7fff_ffff);
        repeat (wait_cycles) @(posedge clk);
        #1;
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        if (ready !== 1'b1) begin
            $display("ready_o did not return high in the cycle after the flush");
            tb_errors++;
        end
    endtask

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(SEED));
        rst_n       = 1'b0;
        flush       = 1'b0;
        issue_valid = 1'b0;
        op          = MUL;
        operand_a   = '0;
        operand_b   = '0;
        trans_id    = '0;
        next_id     = '0;
        tb_errors   = 0;
        small_vals  = '{32'h0, 32'h1, 32'hffff_ffff};
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        if ((ready !== 1'b1) || (res_valid !== 1'b0)) begin
            $display("unit not idle after reset, ready_o %h valid_o %h", ready, res_valid);
            tb_errors++;
        end
        // random multiplies, an idle cycle now and then
        for (int i = 0; i < NUM_RANDOM; i++) begin
            issue_op(fu_op_e'(OP_BITS'($urandom_range(3, 0))), $urandom, $urandom);
            if ($urandom_range(3, 0) == 0) begin
                @(posedge clk);
                #1;
            end
        end
        // random divides, divisor size spread by a random shift
        for (int i = 0; i < NUM_RANDOM; i++) begin
            issue_op(fu_op_e'(OP_BITS'($urandom_range(7, 4))), $urandom,
                     $urandom >> $urandom_range(31, 0));
        end
        // by zero with negative and positive dividend, then min by -1
        for (int k = 4; k < 8; k++) begin
            issue_op(fu_op_e'(OP_BITS'(k)), 32'h8765_4321, '0);
            issue_op(fu_op_e'(OP_BITS'(k)), 32'd5, '0);
            issue_op(fu_op_e'(OP_BITS'(k)), XLEN_MIN, '1);
        end
        // zero, one and all ones on both sides
        for (int k = 0; k < 8; k++) begin
            for (int ia = 0; ia < 3; ia++) begin
                for (int ib = 0; ib < 3; ib++) begin
                    issue_op(fu_op_e'(OP_BITS'(k)), small_vals[ia], small_vals[ib]);
                end
            end
        end
        for (int i = 0; i < 4; i++) begin
            issue_op(MULHSU, $urandom | XLEN_MIN, $urandom);
        end
        // multiply then a 2-cycle divide, results leave on back-to-back cycles
        issue_op(MUL, $urandom, $urandom);
        issue_op(DIV, $urandom, '0);
        issue_op(MULH, $urandom, $urandom);
        issue_op(REM, XLEN_MIN, '1);
        issue_op(MULHU, $urandom, $urandom);
        issue_op(DIVU, $urandom, '0);
        issue_op(MULHSU, $urandom, $urandom);
        issue_op(REMU, $urandom, '0);
        // flush mid divide, then the unit must still work
        for (int r = 0; r < 3; r++) begin
            flush_divide(r[0] ? REM : DIVU, 5 + 7 * r);
            issue_op(MUL, $urandom, $urandom);
            issue_op(DIV, $urandom, $urandom);
        end
        // drain, then a few more cycles to catch stray results
        for (int i = 0; (i < 100) && (pending_count != 0); i++) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        if (pending_count != 0) begin
            $display("%0d issued operations never returned a result", pending_count);
            tb_errors++;
        end
        $display("errors: checker %0d, testbench %0d", chk_errors, tb_errors);
        if ((chk_errors + tb_errors) == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout, the run did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* verilog.f */
src/muldiv_pkg.sv
src/muldiv_req_if.sv
src/muldiv_res_if.sv
src/muldiv_decode.sv
src/pipe_multiplier.sv
src/serial_divider.sv
src/muldiv_unit.sv
test/muldiv_checker.sv
test/tb_muldiv_unit.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module tb_muldiv_unit -f verilog.f -o tb_muldiv_unit
	@out="$$(./obj_dir/tb_muldiv_unit)"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
